// ==== include/core_settings.svh ====
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// Core geometry
`define CORE_THREADS 4
`define CORE_REGS    16
`define DATA_W       32

// Index widths, tied to the counts above
`define TID_W        2
`define RADDR_W      4

// MOV r0, r0 with condition AL
`define NOP_INSTR    32'hE1A0_0000

`endif

// ==== verilog/arm_isa_pkg.sv ====
`include "core_settings.svh"

package arm_isa_pkg;

    typedef logic [`DATA_W-1:0]  word_t;
    typedef logic [`TID_W-1:0]   tid_t;
    typedef logic [`RADDR_W-1:0] reg_idx_t;

    // Condition field, instr[31:28]
    typedef enum logic [3:0] {
        COND_EQ = 4'h0,
        COND_NE = 4'h1,
        COND_CS = 4'h2,
        COND_CC = 4'h3,
        COND_MI = 4'h4,
        COND_PL = 4'h5,
        COND_VS = 4'h6,
        COND_VC = 4'h7,
        COND_HI = 4'h8,
        COND_LS = 4'h9,
        COND_GE = 4'hA,
        COND_LT = 4'hB,
        COND_GT = 4'hC,
        COND_LE = 4'hD,
        COND_AL = 4'hE,
        COND_NV = 4'hF
    } cond_e;

    // Data-processing opcode, instr[24:21]
    typedef enum logic [3:0] {
        OP_SUB = 4'b0010,
        OP_ADD = 4'b0100,
        OP_CMP = 4'b1010,
        OP_MOV = 4'b1101
    } dp_opcode_e;

    typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_PASS_B} alu_op_e;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flags_t;

endpackage

// ==== verilog/core_pipe_pkg.sv ====
`include "core_settings.svh"

package core_pipe_pkg;

    import arm_isa_pkg::*;

    // Instruction as handed in from outside
    typedef struct packed {
        tid_t                tid;
        logic [`DATA_W-1:0]  instr;
    } issue_t;

    // id/ex register contents
    typedef struct packed {
        logic     valid;
        tid_t     tid;
        cond_e    cond;
        alu_op_e  alu_op;
        word_t    op_a;      // Rn
        word_t    op_b;      // Immediate or Rm
        reg_idx_t rd;
        logic     reg_write;
        logic     set_flags;
    } ex_ctrl_t;

    typedef struct packed {
        tid_t     tid;
        reg_idx_t rd;
        word_t    data;
    } wb_t;

endpackage

// ==== verilog/alu.sv ====
`timescale 1ns/100ps

module alu (
    input  arm_isa_pkg::word_t    a,
    input  arm_isa_pkg::word_t    b,
    input  arm_isa_pkg::alu_op_e  op,
    output arm_isa_pkg::word_t    result,
    output arm_isa_pkg::flags_t   flags
);
    import arm_isa_pkg::*;

    localparam int MSB = $bits(word_t) - 1;

    logic [MSB+1:0] sum;
    logic           ovf;

    always_comb begin
        sum = '0;
        ovf = 1'b0;
        case (op)
            ALU_ADD: begin
                sum = {1'b0, a} + {1'b0, b};
                ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            end
            ALU_SUB: begin
                // Carry out is NOT borrow, as ARM defines it
                sum = {1'b0, a} + {1'b0, ~b} + 1'b1;
                ovf = (a[MSB] != b[MSB]) && (sum[MSB] != a[MSB]);
            end
            default: sum = {1'b0, b};  // Pass B, C stays 0
        endcase
    end

    assign result  = sum[MSB:0];
    assign flags.n = sum[MSB];
    assign flags.z = (sum[MSB:0] == '0);
    assign flags.c = sum[MSB+1];
    assign flags.v = ovf;

    a_op_legal: assert final (op inside {ALU_ADD, ALU_SUB, ALU_PASS_B})
        else $error("illegal ALU op %0b", op);

endmodule

// ==== verilog/cpsr_bank.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module cpsr_bank (
    input  logic                clk,
    input  logic                rstb,
    input  arm_isa_pkg::tid_t   rd_tid,
    output arm_isa_pkg::flags_t cur_flags,
    input  logic                update,
    input  arm_isa_pkg::flags_t new_flags
);
    import arm_isa_pkg::*;

    flags_t cpsr [`CORE_THREADS];

    assign cur_flags = cpsr[rd_tid];

    // Read and write thread are both the one in execute
    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int i = 0; i < `CORE_THREADS; i++)
                cpsr[i] <= '0;
        end else if (update) begin
            cpsr[rd_tid] <= new_flags;
        end
    end

endmodule

// ==== verilog/thread_regfile.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module thread_regfile (
    input  logic                  clk,
    input  logic                  rstb,
    input  arm_isa_pkg::tid_t     rd_tid,
    input  arm_isa_pkg::reg_idx_t rn_idx,
    input  arm_isa_pkg::reg_idx_t rm_idx,
    output arm_isa_pkg::word_t    rn_data,
    output arm_isa_pkg::word_t    rm_data,
    input  logic                  wb_valid,
    input  core_pipe_pkg::wb_t    wb
);
    import arm_isa_pkg::*;

    word_t regs [`CORE_THREADS*`CORE_REGS];

    logic [`TID_W+`RADDR_W-1:0] rn_addr;
    logic [`TID_W+`RADDR_W-1:0] rm_addr;
    logic [`TID_W+`RADDR_W-1:0] wr_addr;

    assign rn_addr = {rd_tid, rn_idx};
    assign rm_addr = {rd_tid, rm_idx};
    assign wr_addr = {wb.tid, wb.rd};

    // Writeback lands next edge, so forward it now
    assign rn_data = (wb_valid && wr_addr == rn_addr) ? wb.data : regs[rn_addr];
    assign rm_data = (wb_valid && wr_addr == rm_addr) ? wb.data : regs[rm_addr];

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            for (int i = 0; i < `CORE_THREADS*`CORE_REGS; i++)
                regs[i] <= '0;
        end else if (wb_valid) begin
            regs[wr_addr] <= wb.data;
        end
    end

endmodule

// ==== verilog/decode_stage.sv ====
`timescale 1ns/100ps
`include "core_settings.svh"

module decode_stage (
    input  logic                    clk,
    input  logic                    rstb,
    input  logic                    issue_valid,
    input  core_pipe_pkg::issue_t   issue,
    output arm_isa_pkg::tid_t       rd_tid,
    output arm_isa_pkg::reg_idx_t   rn_idx,
    output arm_isa_pkg::reg_idx_t   rm_idx,
    input  arm_isa_pkg::word_t      rn_data,
    input  arm_isa_pkg::word_t      rm_data,
    output core_pipe_pkg::ex_ctrl_t ex_ctrl
);
    import arm_isa_pkg::*;
    import core_pipe_pkg::*;

    issue_t     issue_q;
    logic       issue_q_valid;
    word_t      instr;
    dp_opcode_e opcode;
    logic       imm_form;
    logic       is_dp;
    logic       op_known;
    alu_op_e    alu_op;
    logic       reg_write;
    logic       set_flags;
    logic [63:0] imm_dbl;
    word_t      imm_val;

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            issue_q_valid <= 1'b0;
            issue_q       <= '{tid: '0, instr: `NOP_INSTR};
        end else begin
            issue_q_valid <= issue_valid;
            if (issue_valid)
                issue_q <= issue;
        end
    end

    assign instr    = issue_q.instr;
    assign rd_tid   = issue_q.tid;
    assign rn_idx   = instr[19:16];
    assign rm_idx   = instr[3:0];
    assign imm_form = instr[25];

    // imm8 rotated right by twice the rotate field
    assign imm_dbl = {2{24'b0, instr[7:0]}} >> {instr[11:8], 1'b0};
    assign imm_val = imm_dbl[31:0];

    always_comb begin
        opcode    = dp_opcode_e'(instr[24:21]);
        // Register form only without a shift
        is_dp     = (instr[27:26] == 2'b00) && (imm_form || instr[11:4] == 8'h00);
        op_known  = 1'b1;
        alu_op    = ALU_PASS_B;
        reg_write = 1'b0;
        set_flags = 1'b0;
        case (opcode)
            OP_MOV: begin
                reg_write = 1'b1;
                set_flags = instr[20];
            end
            OP_ADD: begin
                alu_op    = ALU_ADD;
                reg_write = 1'b1;
                set_flags = instr[20];
            end
            OP_SUB: begin
                alu_op    = ALU_SUB;
                reg_write = 1'b1;
                set_flags = instr[20];
            end
            OP_CMP: begin
                alu_op    = ALU_SUB;
                set_flags = 1'b1;  // Flags only, no result
            end
            default: op_known = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb) begin
            ex_ctrl <= '0;
        end else begin
            ex_ctrl.valid     <= issue_q_valid && is_dp && op_known;
            ex_ctrl.tid       <= issue_q.tid;
            ex_ctrl.cond      <= cond_e'(instr[31:28]);
            ex_ctrl.alu_op    <= alu_op;
            ex_ctrl.op_a      <= rn_data;
            ex_ctrl.op_b      <= imm_form ? imm_val : rm_data;
            ex_ctrl.rd        <= instr[15:12];
            ex_ctrl.reg_write <= reg_write;
            ex_ctrl.set_flags <= set_flags;
        end
    end

    // Back-to-back issue from one thread would miss the writeback bypass
    a_thread_spacing: assert property (@(posedge clk) disable iff (!rstb)
        issue_valid && $past(issue_valid) |-> issue.tid != $past(issue.tid))
        else $error("thread %0d issued on consecutive cycles", issue.tid);

endmodule

// ==== verilog/execute_stage.sv ====
`timescale 1ns/100ps

module execute_stage (
    input  logic                    clk,
    input  logic                    rstb,
    input  core_pipe_pkg::ex_ctrl_t ex_ctrl,
    output arm_isa_pkg::tid_t       flags_tid,
    input  arm_isa_pkg::flags_t     cur_flags,
    output logic                    flag_update,
    output arm_isa_pkg::flags_t     new_flags,
    output logic                    wb_valid,
    output core_pipe_pkg::wb_t      wb
);
    import arm_isa_pkg::*;
    import core_pipe_pkg::*;

    word_t  alu_result;
    flags_t alu_flags;
    logic   cond_ok;
    logic   exec;

    function automatic logic cond_pass(cond_e cond, flags_t f);
        case (cond)
            COND_EQ: return f.z;
            COND_NE: return !f.z;
            COND_CS: return f.c;
            COND_CC: return !f.c;
            COND_MI: return f.n;
            COND_PL: return !f.n;
            COND_VS: return f.v;
            COND_VC: return !f.v;
            COND_HI: return f.c && !f.z;
            COND_LS: return !f.c || f.z;
            COND_GE: return f.n == f.v;
            COND_LT: return f.n != f.v;
            COND_GT: return !f.z && (f.n == f.v);
            COND_LE: return f.z || (f.n != f.v);
            COND_AL: return 1'b1;
            default: return 1'b0;  // NV
        endcase
    endfunction

    alu i_alu (
        .a      (ex_ctrl.op_a),
        .b      (ex_ctrl.op_b),
        .op     (ex_ctrl.alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

    assign flags_tid   = ex_ctrl.tid;
    assign cond_ok     = cond_pass(ex_ctrl.cond, cur_flags);
    assign exec        = ex_ctrl.valid && cond_ok;
    assign flag_update = exec && ex_ctrl.set_flags;
    assign new_flags   = alu_flags;  // C and V already 0 for MOV

    always_ff @(posedge clk or negedge rstb) begin
        if (!rstb)
            wb_valid <= 1'b0;
        else
            wb_valid <= exec && ex_ctrl.reg_write;
    end

    always_ff @(posedge clk) begin
        if (exec && ex_ctrl.reg_write)
            wb <= '{tid: ex_ctrl.tid, rd: ex_ctrl.rd, data: alu_result};
    end

    a_wb_valid_known: assert property (@(posedge clk) disable iff (!rstb)
        !$isunknown(wb_valid))
        else $error("wb_valid unknown");

endmodule

// ==== verilog/mt_arm_core.sv ====
`timescale 1ns/100ps

module mt_arm_core (
    input  logic                  clk,
    input  logic                  rstb,
    input  logic                  issue_valid,
    input  core_pipe_pkg::issue_t issue,
    output logic                  wb_valid,
    output core_pipe_pkg::wb_t    wb
);
    import arm_isa_pkg::*;
    import core_pipe_pkg::*;

    tid_t     rd_tid;
    reg_idx_t rn_idx;
    reg_idx_t rm_idx;
    word_t    rn_data;
    word_t    rm_data;
    ex_ctrl_t ex_ctrl;
    tid_t     flags_tid;
    flags_t   cur_flags;
    logic     flag_update;
    flags_t   new_flags;

    decode_stage i_decode_stage (
        .clk         (clk),
        .rstb        (rstb),
        .issue_valid (issue_valid),
        .issue       (issue),
        .rd_tid      (rd_tid),
        .rn_idx      (rn_idx),
        .rm_idx      (rm_idx),
        .rn_data     (rn_data),
        .rm_data     (rm_data),
        .ex_ctrl     (ex_ctrl)
    );

    thread_regfile i_thread_regfile (
        .clk      (clk),
        .rstb     (rstb),
        .rd_tid   (rd_tid),
        .rn_idx   (rn_idx),
        .rm_idx   (rm_idx),
        .rn_data  (rn_data),
        .rm_data  (rm_data),
        .wb_valid (wb_valid),
        .wb       (wb)
    );

    execute_stage i_execute_stage (
        .clk         (clk),
        .rstb        (rstb),
        .ex_ctrl     (ex_ctrl),
        .flags_tid   (flags_tid),
        .cur_flags   (cur_flags),
        .flag_update (flag_update),
        .new_flags   (new_flags),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    cpsr_bank i_cpsr_bank (
        .clk       (clk),
        .rstb      (rstb),
        .rd_tid    (flags_tid),
        .cur_flags (cur_flags),
        .update    (flag_update),
        .new_flags (new_flags)
    );

endmodule

// ==== test/tb_mt_arm_core.sv ====
`timescale 1ns/100ps

module tb_mt_arm_core;
    import arm_isa_pkg::*;
    import core_pipe_pkg::*;

    localparam int MAX_VEC = 64;
    localparam int VEC_FIELDS = 5;
    localparam int PIPE_SLOTS = 3;  // Issue to observed writeback in driver steps

    logic   clk;
    logic   rstb;
    logic   issue_valid;
    issue_t issue;
    logic   wb_valid;
    wb_t    wb;

    logic [31:0] vec_mem [MAX_VEC*VEC_FIELDS];
    int          n_vec;
    logic [31:0] rand_state;

    // Expected outcome per issue slot in issue order
    logic        wr_q [$];
    wb_t         wb_q [$];

    mt_arm_core i_mt_arm_core (
        .clk         (clk),
        .rstb        (rstb),
        .issue_valid (issue_valid),
        .issue       (issue),
        .wb_valid    (wb_valid),
        .wb          (wb)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run();
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_wb(input logic got_valid, input wb_t got, input wb_t exp);
        if (got_valid !== 1'b1) begin
            $display("ERROR %0t: writeback missing, want tid %0d rd %0d data %08h",
                     $time, exp.tid, exp.rd, exp.data);
            fail_run();
        end else if (got !== exp) begin
            $display("ERROR %0t: got tid %0d rd %0d data %08h, want tid %0d rd %0d data %08h",
                     $time, got.tid, got.rd, got.data, exp.tid, exp.rd, exp.data);
            fail_run();
        end
    endtask

    task automatic check_quiet(input logic got_valid);
        if (got_valid !== 1'b0) begin
            $display("ERROR %0t: unexpected writeback, wb_valid %b tid %0d rd %0d data %08h",
                     $time, got_valid, wb.tid, wb.rd, wb.data);
            fail_run();
        end
    endtask

    // Checks the slot issued three steps back and drives the next one
    task automatic run_slot(input logic v, input issue_t iss, input logic exp_wr,
                            input wb_t exp_wb);
        logic slot_wr;
        wb_t  slot_wb;
        @(posedge clk);
        #0.5;
        if (wr_q.size() == PIPE_SLOTS) begin
            slot_wr = wr_q.pop_front();
            slot_wb = wb_q.pop_front();
            if (slot_wr)
                check_wb(wb_valid, wb, slot_wb);
            else
                check_quiet(wb_valid);
        end
        issue_valid = v;
        issue       = iss;
        wr_q.push_back(exp_wr);
        wb_q.push_back(exp_wb);
    endtask

    // Watchdog
    initial begin
        int limit;
        wait (rstb === 1'b1);
        limit = n_vec * 5 + 40;
        repeat (limit) @(posedge clk);
        $display("Run timed out after %0d cycles without finishing the vectors", limit);
        fail_run();
    end

    initial begin
        int     base;
        int     idle;
        issue_t iss;
        wb_t    exp_wb;
        logic   exp_wr;

        rstb        = 1'b0;
        issue_valid = 1'b0;
        issue       = '0;
        rand_state  = 32'hbd2a;
        n_vec       = 0;

        // Thread field above 3 marks the end of the vectors
        for (int i = 0; i < MAX_VEC*VEC_FIELDS; i++)
            vec_mem[i] = 32'hFFFF_0000 | i;
        $readmemh("test/core_vectors.txt", vec_mem);
        while (n_vec < MAX_VEC && vec_mem[n_vec*VEC_FIELDS] <= 32'd3)
            n_vec++;
        if (n_vec == 0) begin
            $display("No vectors could be read from test/core_vectors.txt");
            fail_run();
        end

        repeat (16) @(posedge clk);
        #0.5;
        rstb = 1'b1;

        for (int i = 0; i < n_vec; i++) begin
            base       = i * VEC_FIELDS;
            iss.tid    = vec_mem[base][1:0];
            iss.instr  = vec_mem[base+1];
            exp_wr     = vec_mem[base+2][0];
            exp_wb.tid = vec_mem[base][1:0];
            exp_wb.rd  = vec_mem[base+3][3:0];
            exp_wb.data = vec_mem[base+4];
            run_slot(1'b1, iss, exp_wr, exp_wb);

            rand_state = next_rand(rand_state);
            idle = int'(rand_state[17:16]);  // 0 to 3 idle cycles
            repeat (idle) run_slot(1'b0, '0, 1'b0, '0);
        end

        // Drain the pipe
        repeat (PIPE_SLOTS) run_slot(1'b0, '0, 1'b0, '0);

        $display("=== PASS ===");
        $finish;
    end

endmodule

// ==== test/core_vectors.txt ====
// tid  instr     wr  rd  data   (all hex)
// Round-robin over threads 0..3, wr=0 means no writeback expected
0 E3A014FF 1 1 FF000000
1 E3A01005 1 1 00000005
2 E3A0247F 1 2 7F000000
3 E0843005 1 3 00000000
0 E3A02010 1 2 00000010
1 E3A02003 1 2 00000003
2 E0923002 1 3 FE000000
3 E3530000 0 0 00000000
0 E0813002 1 3 FF000010
1 E0813002 1 3 00000008
2 63A04001 1 4 00000001
3 03A06022 1 6 00000022
0 E0434001 1 4 00000010
1 E0424001 1 4 FFFFFFFE
2 23A05002 0 5 00000000
3 13A07001 0 7 00000000
0 E3510000 0 0 00000000
1 E3B05000 1 5 00000000
2 E3B06102 1 6 80000000
3 03A08033 1 8 00000033
0 43A09004 1 9 00000004
1 03A09007 1 9 00000007
2 63A07009 0 7 00000000
3 E2011001 0 1 00000000
0 E5912000 0 2 00000000
1 E084A002 1 A 00000001
2 43A08001 1 8 00000001
3 E0862008 1 2 00000055

// ==== mt_arm_core.f ====
+incdir+include
verilog/arm_isa_pkg.sv
verilog/core_pipe_pkg.sv
verilog/alu.sv
verilog/cpsr_bank.sv
verilog/thread_regfile.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mt_arm_core.sv
test/tb_mt_arm_core.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/100ps -j 0
TOP      = tb_mt_arm_core
FILELIST = mt_arm_core.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F "=== PASS ===" > /dev/null

clean:
	rm -rf obj_dir
